/* run.sh */
#!/bin/sh
# build the mesh testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -j 0 --top-module mesh_tb -f tb.f \
  && ./obj_dir/Vmesh_tb +verilator+error+limit+1000 > sim.log 2>&1 || echo "build or run error"
cat sim.log 2>/dev/null
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0

/* tb.f */
verilog/mesh_pkg.sv
verilog/mesh_router.sv
verilog/mem_tile.sv
verilog/mesh_array.sv
verif/mesh_chk.sv
verif/mesh_tb.sv

/* verif/mesh_chk.sv */
//**************************************************************************
// mesh router checker: fifo overflow, x routing and reset quiet outputs
//**************************************************************************

`timescale 1ns/100ps
`default_nettype none

module mesh_chk
  #(parameter mesh_pkg::x_cord_t my_x_p = '0)
  (
    input  logic                                            clk_i
    , input  logic                                          reset_i
    , input  mesh_pkg::mesh_link_s [mesh_pkg::num_dirs-1:0] links_i
    , input  mesh_pkg::mesh_link_s [mesh_pkg::num_dirs-1:0] links_o
    , input  logic [mesh_pkg::num_dirs-1:0]                 fifo_full_i
  );

  logic [mesh_pkg::num_dirs-1:0] in_v;
  logic [mesh_pkg::num_dirs-1:0] out_v;

  always_comb
  begin
    for (int d = 0; d < mesh_pkg::num_dirs; d++)
    begin
      in_v[d]  = links_i[d].v;
      out_v[d] = links_o[d].v;
    end
  end

  // a strobe into a full fifo is lost, there is no back-pressure
  no_overflow_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (in_v & fifo_full_i) == '0)
  else
  begin
    $error("input strobe while fifo full");
    mesh_tb.assert_fails++;
  end

  // x is resolved first, so a packet in its own column never turns east or west
  east_x_a: assert property (@(posedge clk_i) disable iff (reset_i)
    links_o[mesh_pkg::E].v |-> (links_o[mesh_pkg::E].pkt.dst_x != my_x_p))
  else
  begin
    $error("east output with dst_x equal to router x");
    mesh_tb.assert_fails++;
  end

  west_x_a: assert property (@(posedge clk_i) disable iff (reset_i)
    links_o[mesh_pkg::W].v |-> (links_o[mesh_pkg::W].pkt.dst_x != my_x_p))
  else
  begin
    $error("west output with dst_x equal to router x");
    mesh_tb.assert_fails++;
  end

  // outputs clear one edge into reset and stay low
  reset_quiet_a: assert property (@(posedge clk_i)
    (reset_i && $past(reset_i)) |-> (out_v == '0))
  else
  begin
    $error("output strobe during reset");
    mesh_tb.assert_fails++;
  end

endmodule

`default_nettype wire

/* verif/mesh_tb.sv */
//**************************************************************************
// mesh testbench: io port traffic checked against a reference memory model
//**************************************************************************

`timescale 1ns/100ps
`default_nettype none

module mesh_tb;

  localparam int num_x_lp      = 2;
  localparam int num_y_lp      = 2;
  localparam int dmem_words_lp = 16;
  localparam int ref_words_lp  = num_x_lp * num_y_lp * dmem_words_lp;
  localparam int ref_idx_lp    = $clog2(ref_words_lp);
  localparam int timeout_lp    = 2000;

  // one outstanding load, keyed by io column, source tile and address
  typedef struct packed
  {
    mesh_pkg::x_cord_t               io_x;
    mesh_pkg::x_cord_t               src_x;
    mesh_pkg::y_cord_t               src_y;
    logic [mesh_pkg::addr_width-1:0] addr;
    logic [mesh_pkg::data_width-1:0] data;
  } exp_resp_s;

  logic                                clk_i;
  logic                                reset_i;
  mesh_pkg::mesh_link_s [num_x_lp-1:0] io_link_i;
  mesh_pkg::mesh_link_s [num_x_lp-1:0] io_link_o;

  logic [mesh_pkg::data_width-1:0]     ref_mem [ref_words_lp];
  exp_resp_s                           exp_q [$];
  int                                  errors = 0;
  int                                  checks = 0;
  int                                  assert_fails = 0;

  mesh_array dut0
    (.clk_i      (clk_i)
     ,.reset_i   (reset_i)
     ,.io_link_i (io_link_i)
     ,.io_link_o (io_link_o)
    );

  bind mesh_router mesh_chk
    #(.my_x_p (my_x_p))
    chk0
    (.clk_i        (clk_i)
     ,.reset_i     (reset_i)
     ,.links_i     (links_i)
     ,.links_o     (links_o)
     ,.fifo_full_i (fifo_full)
    );

  initial
  begin
    clk_i = 1'b0;
    forever
      #5 clk_i = ~clk_i;
  end

  // tile rows start at y = 1, the address wraps onto the tile memory
  function automatic logic [ref_idx_lp-1:0] ref_index(input int tx, input int ty,
                                                      input logic [7:0] addr);
    return ref_idx_lp'((tx * num_y_lp + ty - 1) * dmem_words_lp + int'(addr) % dmem_words_lp);
  endfunction

  function automatic logic [31:0] ref_load(input int tx, input int ty, input logic [7:0] addr);
    return ref_mem[ref_index(tx, ty, addr)];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  // builds a request and updates the model or the expected list
  function automatic mesh_pkg::mesh_link_s issue_req(input int io, input mesh_pkg::mesh_op_e op,
    input int tx, input int ty, input logic [7:0] addr, input logic [31:0] data);
    mesh_pkg::mesh_link_s l;
    exp_resp_s            e;
    l.v         = 1'b1;
    l.pkt.op    = op;
    l.pkt.dst_x = mesh_pkg::x_cord_t'(tx);
    l.pkt.dst_y = mesh_pkg::y_cord_t'(ty);
    l.pkt.src_x = mesh_pkg::x_cord_t'(io);
    l.pkt.src_y = '0;
    l.pkt.addr  = addr;
    l.pkt.data  = data;
    if (op == mesh_pkg::OP_STORE)
      ref_mem[ref_index(tx, ty, addr)] = data;
    else
    begin
      e = {mesh_pkg::x_cord_t'(io), l.pkt.dst_x, l.pkt.dst_y, addr, ref_load(tx, ty, addr)};
      exp_q.push_back(e);
    end
    return l;
  endfunction

  // one slot is four cycles, so each port injects at most every fourth cycle
  task automatic inject_slot(input mesh_pkg::mesh_link_s [num_x_lp-1:0] links);
    @(posedge clk_i);
    #1;
    io_link_i = links;
    @(posedge clk_i);
    #1;
    io_link_i = '0;
    repeat (2) @(posedge clk_i);
  endtask

  task automatic send_one(input int io, input mesh_pkg::mesh_link_s l);
    mesh_pkg::mesh_link_s [num_x_lp-1:0] links;
    links     = '0;
    links[io] = l;
    inject_slot(links);
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles)
    begin
      @(negedge clk_i);
      for (int c = 0; c < num_x_lp; c++)
        check_value("io_link_o.v", 32'(io_link_o[c].v), 32'd0);
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < timeout_lp)
    begin
      @(posedge clk_i);
      cycles++;
    end
    if (exp_q.size() != 0)
    begin
      $display("timeout: %0d loads got no response within %0d cycles", exp_q.size(), timeout_lp);
      errors++;
      exp_q.delete();
    end
    // a stray late response still gets flagged
    repeat (10) @(posedge clk_i);
  endtask

  // each port owns the words of its own parity so no two ports race on a word
  task automatic random_traffic(input int slots);
    mesh_pkg::mesh_link_s [num_x_lp-1:0] links;
    mesh_pkg::mesh_op_e                  op;
    logic [7:0]                          addr;
    for (int s = 0; s < slots; s++)
    begin
      links = '0;
      for (int c = 0; c < num_x_lp; c++)
        if ($urandom_range(3) != 0)
        begin
          op   = ($urandom_range(1) == 0) ? mesh_pkg::OP_STORE : mesh_pkg::OP_LOAD;
          addr = 8'($urandom_range(255 / num_x_lp) * num_x_lp + c);
          links[c] = issue_req(c, op, int'($urandom_range(num_x_lp - 1)),
                               1 + int'($urandom_range(num_y_lp - 1)), addr, $urandom());
        end
      inject_slot(links);
    end
  endtask

  task automatic match_response(input int col, input mesh_pkg::mesh_pkt_s pkt);
    int hit;
    hit = -1;
    for (int k = 0; k < exp_q.size(); k++)
      if (hit < 0 && exp_q[k].io_x == mesh_pkg::x_cord_t'(col) && exp_q[k].src_x == pkt.src_x
          && exp_q[k].src_y == pkt.src_y && exp_q[k].addr == pkt.addr)
        hit = k;
    if (hit < 0)
    begin
      $display("unexpected response at io column %0d from tile (%0d,%0d) addr 0x%02h",
               col, pkt.src_x, pkt.src_y, pkt.addr);
      errors++;
    end
    else
    begin
      check_value("io_link_o.pkt.op", 32'(pkt.op), 32'(mesh_pkg::OP_RESP));
      check_value("io_link_o.pkt.dst_x", 32'(pkt.dst_x), 32'(col));
      check_value("io_link_o.pkt.dst_y", 32'(pkt.dst_y), 32'd0);
      check_value("io_link_o.pkt.data", pkt.data, exp_q[hit].data);
      exp_q.delete(hit);
    end
  endtask

  // compares every io response strobe, mid-cycle where outputs are stable
  always @(negedge clk_i)
  begin
    for (int c = 0; c < num_x_lp; c++)
      if (io_link_o[c].v === 1'b1)
        match_response(c, io_link_o[c].pkt);
  end

  initial
  begin
    logic [7:0] addr;
    void'($urandom(32'h2a43));
    io_link_i = '0;
    reset_i   = 1'b1;
    for (int w = 0; w < ref_words_lp; w++)
      ref_mem[w] = '0;

    // 8 reset cycles, watched once the reset pipeline has filled
    repeat (4) @(posedge clk_i);
    check_idle(4);
    @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_idle(20);

    // loads before any store read zero
    for (int io = 0; io < num_x_lp; io++)
      for (int tx = 0; tx < num_x_lp; tx++)
        for (int ty = 1; ty <= num_y_lp; ty++)
          send_one(io, issue_req(io, mesh_pkg::OP_LOAD, tx, ty, 8'(4 * tx + ty + io), '0));
    wait_drain();

    // store then load from one port, both follow the same xy path
    for (int io = 0; io < num_x_lp; io++)
      for (int tx = 0; tx < num_x_lp; tx++)
        for (int ty = 1; ty <= num_y_lp; ty++)
        begin
          addr = 8'(2 * (tx * num_y_lp + ty) + io);
          send_one(io, issue_req(io, mesh_pkg::OP_STORE, tx, ty, addr, $urandom()));
          send_one(io, issue_req(io, mesh_pkg::OP_LOAD, tx, ty, addr, '0));
        end
    wait_drain();

    // addresses one and three memory sizes apart hit the same word
    for (int tx = 0; tx < num_x_lp; tx++)
      for (int ty = 1; ty <= num_y_lp; ty++)
      begin
        addr = 8'(2 * (tx * num_y_lp + ty) + tx);
        send_one(tx, issue_req(tx, mesh_pkg::OP_STORE, tx, ty, addr, $urandom()));
        send_one(tx, issue_req(tx, mesh_pkg::OP_LOAD, tx, ty, addr + 8'(dmem_words_lp), '0));
        send_one(tx, issue_req(tx, mesh_pkg::OP_STORE, tx, ty,
                               addr + 8'(3 * dmem_words_lp), $urandom()));
        send_one(tx, issue_req(tx, mesh_pkg::OP_LOAD, tx, ty, addr, '0));
      end
    wait_drain();

    random_traffic(250);
    wait_drain();

    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/mem_tile.sv */
//**************************************************************************
// memory tile: runs stores and loads, returns load data to the sender
//**************************************************************************

`timescale 1ns/100ps
`default_nettype none

module mem_tile
  #(parameter mesh_pkg::x_cord_t my_x_p = '0
    , parameter mesh_pkg::y_cord_t my_y_p = '0
    , parameter int dmem_words_p = 16
  )
  (
    input  logic                   clk_i
    , input  logic                 reset_i
    , input  mesh_pkg::mesh_link_s req_i
    , output mesh_pkg::mesh_link_s resp_o
  );

  localparam int idx_width_lp = (dmem_words_p > 1) ? $clog2(dmem_words_p) : 1;

  logic [mesh_pkg::data_width-1:0] dmem [dmem_words_p];
  logic [idx_width_lp-1:0]         idx;
  logic                            is_store;
  logic                            is_load;

  logic                            resp_v;
  mesh_pkg::mesh_pkt_s             resp_pkt;

  // address wraps onto the memory size
  assign idx = idx_width_lp'(req_i.pkt.addr % dmem_words_p);

  // responses that land here are dropped
  assign is_store = req_i.v && (req_i.pkt.op == mesh_pkg::OP_STORE);
  assign is_load  = req_i.v && (req_i.pkt.op == mesh_pkg::OP_LOAD);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int w = 0; w < dmem_words_p; w++)
        dmem[w] <= '0;
    end
    else if (is_store)
    begin
      dmem[idx] <= req_i.pkt.data;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v <= 1'b0;
    else
      resp_v <= is_load;
  end

  // reply goes back to the requesting io router
  always_ff @(posedge clk_i)
  begin
    if (is_load)
    begin
      resp_pkt.op    <= mesh_pkg::OP_RESP;
      resp_pkt.dst_x <= req_i.pkt.src_x;
      resp_pkt.dst_y <= req_i.pkt.src_y;
      resp_pkt.src_x <= my_x_p;
      resp_pkt.src_y <= my_y_p;
      resp_pkt.addr  <= req_i.pkt.addr;
      resp_pkt.data  <= dmem[idx];
    end
  end

  assign resp_o.v   = resp_v;
  assign resp_o.pkt = resp_pkt;

endmodule

`default_nettype wire

/* verilog/mesh_array.sv */
//**************************************************************************
// mesh array top: io router row over a grid of memory tiles, with a
// pipelined reset and the mesh stitching
//**************************************************************************

`timescale 1ns/100ps
`default_nettype none

module mesh_array
  #(parameter int num_tiles_x_p = 2
    , parameter int num_tiles_y_p = 2
    , parameter int dmem_words_p = 16
    , parameter int fifo_depth_p = 4
    , parameter int reset_depth_p = 3
  )
  (
    input  logic                                         clk_i
    , input  logic                                       reset_i
    , input  mesh_pkg::mesh_link_s [num_tiles_x_p-1:0]   io_link_i
    , output mesh_pkg::mesh_link_s [num_tiles_x_p-1:0]   io_link_o
  );

  // row 0 holds the io routers, tile rows follow below it
  localparam int num_rows_lp = num_tiles_y_p + 1;

  logic [reset_depth_p-1:0] reset_r;
  logic                     reset_lo;

  // all router outputs, indexed [y][x][dir]
  mesh_pkg::mesh_link_s [mesh_pkg::num_dirs-1:0] link_out [num_rows_lp][num_tiles_x_p];

  // reset shift register
  always_ff @(posedge clk_i)
  begin
    reset_r[0] <= reset_i;
    for (int k = 1; k < reset_depth_p; k++)
      reset_r[k] <= reset_r[k-1];
  end

  assign reset_lo = reset_r[reset_depth_p-1];

  for (genvar y = 0; y < num_rows_lp; y++)
  begin : g_row
    for (genvar x = 0; x < num_tiles_x_p; x++)
    begin : g_col
      mesh_pkg::mesh_link_s p_in;
      mesh_pkg::mesh_link_s w_in;
      mesh_pkg::mesh_link_s e_in;
      mesh_pkg::mesh_link_s n_in;
      mesh_pkg::mesh_link_s s_in;

      // horizontal neighbours, outer edge tied off
      if (x > 0)
      begin : g_w
        assign w_in = link_out[y][x-1][mesh_pkg::E];
      end
      else
      begin : g_w_edge
        assign w_in = '0;
      end

      if (x < num_tiles_x_p - 1)
      begin : g_e
        assign e_in = link_out[y][x+1][mesh_pkg::W];
      end
      else
      begin : g_e_edge
        assign e_in = '0;
      end

      // vertical neighbours
      if (y > 0)
      begin : g_n
        assign n_in = link_out[y-1][x][mesh_pkg::S];
      end
      else
      begin : g_n_edge
        assign n_in = '0;
      end

      if (y < num_rows_lp - 1)
      begin : g_s
        assign s_in = link_out[y+1][x][mesh_pkg::N];
      end
      else
      begin : g_s_edge
        assign s_in = '0;
      end

      // local port is the processor link on row 0, a memory tile elsewhere
      if (y == 0)
      begin : g_io
        assign p_in         = io_link_i[x];
        assign io_link_o[x] = link_out[y][x][mesh_pkg::P];
      end
      else
      begin : g_tile
        mem_tile
          #(.my_x_p       (mesh_pkg::x_cord_t'(x))
            ,.my_y_p       (mesh_pkg::y_cord_t'(y))
            ,.dmem_words_p (dmem_words_p)
          )
          tile0
          (.clk_i    (clk_i)
           ,.reset_i (reset_lo)
           ,.req_i   (link_out[y][x][mesh_pkg::P])
           ,.resp_o  (p_in)
          );
      end

      // input order follows dir_e, {S, N, E, W, P}
      mesh_router
        #(.my_x_p        (mesh_pkg::x_cord_t'(x))
          ,.my_y_p       (mesh_pkg::y_cord_t'(y))
          ,.fifo_depth_p (fifo_depth_p)
        )
        router0
        (.clk_i    (clk_i)
         ,.reset_i (reset_lo)
         ,.links_i ({s_in, n_in, e_in, w_in, p_in})
         ,.links_o (link_out[y][x])
        );
    end
  end

endmodule

`default_nettype wire

/* verilog/mesh_pkg.sv */
//**************************************************************************
// mesh package: packet layout, opcodes and router port indices
//**************************************************************************

`default_nettype none

package mesh_pkg;

  // coordinate widths, covers up to 4 columns and 4 rows with the io row
  parameter int x_cord_width = 2;
  parameter int y_cord_width = 2;

  // word address inside one tile memory
  parameter int addr_width = 8;

  // payload word
  parameter int data_width = 32;

  // router ports, one per direction plus the local port
  parameter int num_dirs = 5;

  typedef logic [x_cord_width-1:0] x_cord_t;
  typedef logic [y_cord_width-1:0] y_cord_t;

  // request and response opcodes
  typedef enum logic [1:0]
  {
    OP_STORE = 2'd0,
    OP_LOAD  = 2'd1,
    OP_RESP  = 2'd2
  } mesh_op_e;

  // link index of each router port, P is the local endpoint
  typedef enum logic [2:0]
  {
    P = 3'd0,
    W = 3'd1,
    E = 3'd2,
    N = 3'd3,
    S = 3'd4
  } dir_e;

  // one packet, dst steers the routers and src is where a reply goes
  typedef struct packed
  {
    mesh_op_e                op;
    x_cord_t                 dst_x;
    y_cord_t                 dst_y;
    x_cord_t                 src_x;
    y_cord_t                 src_y;
    logic [addr_width-1:0]   addr;
    logic [data_width-1:0]   data;
  } mesh_pkt_s;

  // a link carries a packet in any cycle where v is high
  typedef struct packed
  {
    logic      v;
    mesh_pkt_s pkt;
  } mesh_link_s;

endpackage

`default_nettype wire

/* verilog/mesh_router.sv */
//**************************************************************************
// mesh router: five-port xy router with input fifos and round-robin
// output arbitration, outputs are registered
//**************************************************************************

`timescale 1ns/100ps
`default_nettype none

module mesh_router
  #(parameter mesh_pkg::x_cord_t my_x_p = '0
    , parameter mesh_pkg::y_cord_t my_y_p = '0
    , parameter int fifo_depth_p = 4
  )
  (
    input  logic                                            clk_i
    , input  logic                                          reset_i
    , input  mesh_pkg::mesh_link_s [mesh_pkg::num_dirs-1:0] links_i
    , output mesh_pkg::mesh_link_s [mesh_pkg::num_dirs-1:0] links_o
  );

  localparam int ptr_width_lp = (fifo_depth_p > 1) ? $clog2(fifo_depth_p) : 1;
  localparam int cnt_width_lp = $clog2(fifo_depth_p + 1);

  // fifo heads as seen by the arbiters
  mesh_pkg::mesh_pkt_s            head_pkt [mesh_pkg::num_dirs];
  mesh_pkg::dir_e                 head_dir [mesh_pkg::num_dirs];
  logic [mesh_pkg::num_dirs-1:0]  head_valid;
  logic [mesh_pkg::num_dirs-1:0]  fifo_full;
  logic [mesh_pkg::num_dirs-1:0]  pop;

  // req[o][i] is set when the head of input i wants output o
  logic [mesh_pkg::num_dirs-1:0]  req [mesh_pkg::num_dirs];
  logic [mesh_pkg::num_dirs-1:0]  grant_v;
  logic [2:0]                     grant_idx [mesh_pkg::num_dirs];
  logic [2:0]                     last_grant [mesh_pkg::num_dirs];

  logic [mesh_pkg::num_dirs-1:0]  out_v;
  mesh_pkg::mesh_pkt_s            out_pkt [mesh_pkg::num_dirs];

  // dimension-ordered routing, x is resolved before y
  function automatic mesh_pkg::dir_e route_dir(input mesh_pkg::mesh_pkt_s pkt);
    mesh_pkg::dir_e d;
    if (pkt.dst_x > my_x_p)
      d = mesh_pkg::E;
    else if (pkt.dst_x < my_x_p)
      d = mesh_pkg::W;
    else if (pkt.dst_y > my_y_p)
      d = mesh_pkg::S;
    else if (pkt.dst_y < my_y_p)
      d = mesh_pkg::N;
    else
      d = mesh_pkg::P;
    return d;
  endfunction

  // one circular fifo per input port
  for (genvar i = 0; i < mesh_pkg::num_dirs; i++)
  begin : g_fifo
    mesh_pkg::mesh_pkt_s       mem [fifo_depth_p];
    logic [ptr_width_lp-1:0]   wr_ptr;
    logic [ptr_width_lp-1:0]   rd_ptr;
    logic [cnt_width_lp-1:0]   count;
    logic                      push;

    assign fifo_full[i]  = (count == cnt_width_lp'(fifo_depth_p));
    assign push          = links_i[i].v && !fifo_full[i];
    assign head_valid[i] = (count != '0);
    assign head_pkt[i]   = mem[rd_ptr];
    assign head_dir[i]   = route_dir(mem[rd_ptr]);

    always_ff @(posedge clk_i)
    begin
      if (reset_i)
      begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
      end
      else
      begin
        if (push)
          wr_ptr <= (wr_ptr == ptr_width_lp'(fifo_depth_p - 1)) ?
                    '0 : wr_ptr + ptr_width_lp'(1);
        if (pop[i])
          rd_ptr <= (rd_ptr == ptr_width_lp'(fifo_depth_p - 1)) ?
                    '0 : rd_ptr + ptr_width_lp'(1);
        count <= count + cnt_width_lp'(push) - cnt_width_lp'(pop[i]);
      end
    end

    always_ff @(posedge clk_i)
    begin
      if (push)
        mem[wr_ptr] <= links_i[i].pkt;
    end
  end

  // request matrix and one round-robin pick per output
  always_comb
  begin
    int idx;
    for (int o = 0; o < mesh_pkg::num_dirs; o++)
      req[o] = '0;
    for (int i = 0; i < mesh_pkg::num_dirs; i++)
      if (head_valid[i])
        req[head_dir[i]][i] = 1'b1;

    pop     = '0;
    grant_v = '0;
    for (int o = 0; o < mesh_pkg::num_dirs; o++)
    begin
      grant_idx[o] = last_grant[o];
      // search starts just after the previous winner
      for (int k = 1; k <= mesh_pkg::num_dirs; k++)
      begin
        idx = (int'(last_grant[o]) + k) % mesh_pkg::num_dirs;
        if (!grant_v[o] && req[o][idx])
        begin
          grant_v[o]   = 1'b1;
          grant_idx[o] = 3'(idx);
          pop[idx]     = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      out_v <= '0;
      for (int o = 0; o < mesh_pkg::num_dirs; o++)
        last_grant[o] <= 3'(mesh_pkg::num_dirs - 1);
    end
    else
    begin
      out_v <= grant_v;
      for (int o = 0; o < mesh_pkg::num_dirs; o++)
        if (grant_v[o])
          last_grant[o] <= grant_idx[o];
    end
  end

  // winner payload moves into the output register
  always_ff @(posedge clk_i)
  begin
    for (int o = 0; o < mesh_pkg::num_dirs; o++)
      if (grant_v[o])
        out_pkt[o] <= head_pkt[grant_idx[o]];
  end

  always_comb
  begin
    for (int o = 0; o < mesh_pkg::num_dirs; o++)
    begin
      links_o[o].v   = out_v[o];
      links_o[o].pkt = out_pkt[o];
    end
  end

endmodule

`default_nettype wire
